// File: src.f
+incdir+source
+incdir+tb
source/intra_pkg.sv
source/cand_if.sv
source/intra_predictor.sv
source/residual_quantizer.sv
source/block_distortion.sv
source/mode_decision.sv
source/intra_mode_top.sv
tb/tb_intra_mode.sv

// File: tb/intra_mode_tests.svh
// Needs the testbench signals in scope and models scores modulo 2^32

intra_pkg::mode_e   exp_mode;
logic [31:0]        exp_score;
intra_pkg::block_t  exp_recon;
intra_pkg::levels_t exp_levels;
int                 exp_nz;

function automatic int clamp_pixel(int v);
    return (v < 0) ? 0 : ((v > 255) ? 255 : v);
endfunction

function automatic intra_pkg::block_t predict_block(intra_pkg::mode_e m);
    int t [`BLK];
    int l [`BLK];
    int tl;
    int st;
    int sl;
    int dc;
    intra_pkg::block_t p;
    st = 0;
    sl = 0;
    for (int i = 0; i < `BLK; i++) begin
        t[i] = have_top ? int'(top[i]) : 127;
        l[i] = have_left ? int'(left[i]) : 129;
        st += t[i];
        sl += l[i];
    end
    tl = !have_top ? 127 : (!have_left ? 129 : int'(top_left));
    if (have_top && have_left)
        dc = (st + sl + `BLK) / (2 * `BLK);
    else if (have_top)
        dc = (st + `BLK / 2) / `BLK;
    else if (have_left)
        dc = (sl + `BLK / 2) / `BLK;
    else
        dc = 128;
    for (int r = 0; r < `BLK; r++) begin
        for (int c = 0; c < `BLK; c++) begin
            case (m)
                intra_pkg::DC: p[r][c] = 8'(dc);
                intra_pkg::TM: p[r][c] = 8'(clamp_pixel(l[r] + t[c] - tl));
                intra_pkg::VE: p[r][c] = 8'(t[c]);
                default:       p[r][c] = 8'(l[r]);
            endcase
        end
    end
    return p;
endfunction

// Walks HE, VE, TM, DC and keeps the lowest score, later mode on a tie
task automatic model_best();
    intra_pkg::block_t  p;
    intra_pkg::block_t  rec;
    intra_pkg::levels_t lv;
    intra_pkg::mode_e   m;
    int                 res, q, rv, d, rate, nzc, sse;
    logic [31:0]        cost;
    logic [31:0]        sc;
    for (int k = 3; k >= 0; k--) begin
        m    = intra_pkg::mode_e'(k);
        p    = predict_block(m);
        rate = 0;
        nzc  = 0;
        sse  = 0;
        for (int r = 0; r < `BLK; r++) begin
            for (int c = 0; c < `BLK; c++) begin
                res = int'(src[r][c]) - int'(p[r][c]);
                q   = (res < 0 ? -res : res) >> qshift;
                rv  = clamp_pixel(int'(p[r][c]) + (res < 0 ? -(q << qshift) : (q << qshift)));
                lv[r * `BLK + c] = intra_pkg::level_t'(res < 0 ? -q : q);
                rec[r][c] = 8'(rv);
                d    = int'(src[r][c]) - rv;
                sse += d * d;
                rate += q;
                nzc  += (q != 0);
            end
        end
        case (m)
            intra_pkg::DC: cost = `COST_DC;
            intra_pkg::TM: cost = `COST_TM;
            intra_pkg::VE: cost = `COST_VE;
            default:       cost = `COST_HE;
        endcase
        sc = (32'(rate) * 16 + cost) * 32'(lambda) + 32'(sse);
        if (k == 3 || sc <= exp_score) begin
            exp_mode   = m;
            exp_score  = sc;
            exp_recon  = rec;
            exp_levels = lv;
            exp_nz     = nzc;
        end
    end
endtask

task automatic run_case(input string name, input bit recon_is_src);
    bit found;
    int extra;
    int errs;
    if (hung)
        return;
    extra = 0;
    errs  = 0;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    wait_for_done(found);
    if (!found) begin
        $display("%s: no done pulse within %0d cycles", name, TIMEOUT);
        hung = 1'b1;
        fail_cnt++;
        return;
    end
    // done must drop and stay low
    repeat (16) begin
        @(negedge clk);
        if (done)
            extra++;
    end
    model_best();
    if (extra != 0) begin
        $display("%s: done pulsed %0d more times after the first", name, extra);
        errs++;
    end
    if (best_mode !== exp_mode) begin
        $display("FAIL %s best_mode expected %0d actual %0d", name, exp_mode, best_mode);
        errs++;
    end
    if (score !== exp_score) begin
        $display("FAIL %s score expected %0d actual %0d", name, exp_score, score);
        errs++;
    end
    if (nz !== 5'(exp_nz)) begin
        $display("FAIL %s nz expected %0d actual %0d", name, exp_nz, nz);
        errs++;
    end
    if (recon !== exp_recon) begin
        $display("FAIL %s recon expected %h actual %h", name, exp_recon, recon);
        errs++;
    end
    if (levels !== exp_levels) begin
        $display("FAIL %s levels expected %h actual %h", name, exp_levels, levels);
        errs++;
    end
    if (recon_is_src && recon !== src) begin
        $display("FAIL %s recon vs src expected %h actual %h", name, src, recon);
        errs++;
    end
    if (errs == 0) begin
        pass_cnt++;
        $display("test %s passed", name);
    end else begin
        fail_cnt++;
        $display("test %s failed with %0d errors", name, errs);
    end
endtask

task automatic test_flat();
    @(posedge clk);
    have_top  <= 1'b1;
    have_left <= 1'b1;
    top_left  <= 8'd100;
    top       <= {`BLK{8'd100}};
    left      <= {`BLK{8'd100}};
    src       <= {`NPIX{8'd100}};
    qshift    <= 3'd0;
    lambda    <= 16'd1;
    run_case("flat", 1'b0);
endtask

task automatic test_vertical();
    @(posedge clk);
    have_top  <= 1'b1;
    have_left <= 1'b0;
    top_left  <= 8'd33;
    top       <= {8'd10, 8'd200, 8'd10, 8'd200};
    left      <= {`BLK{8'd77}};
    src       <= {`BLK{8'd10, 8'd200, 8'd10, 8'd200}};
    qshift    <= 3'd0;
    lambda    <= 16'd2;
    run_case("vertical", 1'b1);
endtask

task automatic test_no_edges();
    intra_pkg::block_t s;
    for (int r = 0; r < `BLK; r++)
        for (int c = 0; c < `BLK; c++)
            s[r][c] = 8'(100 + 20 * r + 5 * c);
    @(posedge clk);
    have_top  <= 1'b0;
    have_left <= 1'b0;
    src       <= s;
    qshift    <= 3'd1;
    lambda    <= 16'd3;
    run_case("no_edges", 1'b0);
endtask

task automatic test_random();
    intra_pkg::block_t s;
    intra_pkg::row_t   t;
    intra_pkg::row_t   l;
    for (int i = 0; i < 3; i++) begin
        for (int r = 0; r < `BLK; r++) begin
            t[r] = 8'($random(seed));
            l[r] = 8'($random(seed));
            for (int c = 0; c < `BLK; c++)
                s[r][c] = 8'($random(seed));
        end
        @(posedge clk);
        have_top  <= 1'b1;
        have_left <= 1'b1;
        top_left  <= 8'($random(seed));
        top       <= t;
        left      <= l;
        src       <= s;
        qshift    <= 3'd2;
        lambda    <= 16'(($random(seed) & 255) + 1);
        run_case($sformatf("random_%0d", i), 1'b0);
    end
endtask

// Same block twice with a very different lambda
task automatic test_lambda();
    @(posedge clk);
    qshift <= 3'd3;
    lambda <= 16'd1;
    run_case("lambda_low", 1'b0);
    @(posedge clk);
    lambda <= 16'd4000;
    run_case("lambda_high", 1'b0);
endtask

// File: tb/tb_intra_mode.sv
// Runs the directed cases in order and skips the rest after a done timeout
`timescale 1ns/1ns
`include "intra_consts.svh"

module tb_intra_mode;

    localparam int TIMEOUT = 400;

    logic               clk;
    logic               rst_n;
    logic               start;
    logic               have_top;
    logic               have_left;
    intra_pkg::pixel_t  top_left;
    intra_pkg::row_t    top;
    intra_pkg::row_t    left;
    intra_pkg::block_t  src;
    logic [2:0]         qshift;
    logic [15:0]        lambda;
    logic               done;
    intra_pkg::mode_e   best_mode;
    logic [31:0]        score;
    intra_pkg::block_t  recon;
    intra_pkg::levels_t levels;
    logic [4:0]         nz;

    integer seed;
    int     pass_cnt;
    int     fail_cnt;
    bit     hung;

    intra_mode_top DUT (
        .clk(clk), .rst_n(rst_n), .start(start), .have_top(have_top),
        .have_left(have_left), .top_left(top_left), .top(top), .left(left),
        .src(src), .qshift(qshift), .lambda(lambda), .done(done),
        .best_mode(best_mode), .score(score), .recon(recon), .levels(levels),
        .nz(nz)
    );

    always #20 clk = ~clk;

    `include "intra_mode_tests.svh"

    // Sampled on the falling edge, away from the DUT updates
    task automatic wait_for_done(output bit found);
        int cycles;
        cycles = 0;
        found  = 1'b0;
        while (!found && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            found = done;
        end
    endtask

    // ------------------------------------------------------------
    // Reset and test sequence
    // ------------------------------------------------------------
    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        start     = 1'b0;
        have_top  = 1'b0;
        have_left = 1'b0;
        top_left  = '0;
        top       = '0;
        left      = '0;
        src       = '0;
        qshift    = '0;
        lambda    = '0;
        seed      = 56013;
        pass_cnt  = 0;
        fail_cnt  = 0;
        hung      = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        test_flat();
        test_vertical();
        test_no_edges();
        test_random();
        test_lambda();
        $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && !hung)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: source/intra_mode_top.sv
// One block per start, and src, edges, qshift and lambda must hold from start until done
`timescale 1ns/1ns

module intra_mode_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  logic               have_top,
    input  logic               have_left,
    input  intra_pkg::pixel_t  top_left,
    input  intra_pkg::row_t    top,
    input  intra_pkg::row_t    left,
    input  intra_pkg::block_t  src,
    input  logic [2:0]         qshift,
    input  logic [15:0]        lambda,
    output logic               done,
    output intra_pkg::mode_e   best_mode,
    output logic [31:0]        score,
    output intra_pkg::block_t  recon,
    output intra_pkg::levels_t levels,
    output logic [4:0]         nz
);

    intra_pkg::mode_e  mode;
    logic              pred_load;
    logic              q_start;
    intra_pkg::block_t pred;

    cand_if cand ();

    intra_predictor u_pred (
        .clk(clk), .rst_n(rst_n), .pred_load(pred_load), .mode(mode),
        .have_top(have_top), .have_left(have_left), .top_left(top_left),
        .top(top), .left(left), .pred(pred)
    );

    residual_quantizer u_quant (
        .clk(clk), .rst_n(rst_n), .q_start(q_start), .pred(pred), .src(src),
        .qshift(qshift), .cand(cand.quant)
    );

    block_distortion u_disto (
        .clk(clk), .rst_n(rst_n), .src(src), .cand(cand.disto)
    );

    mode_decision u_ctrl (
        .clk(clk), .rst_n(rst_n), .start(start), .lambda(lambda), .cand(cand.ctrl),
        .mode(mode), .pred_load(pred_load), .q_start(q_start),
        .best_mode(best_mode), .score(score), .recon(recon), .levels(levels),
        .nz(nz), .done(done)
    );

endmodule

// File: source/mode_decision.sv
// Scores wrap at 32 bits for extreme rate and lambda and a start is ignored until done
`timescale 1ns/1ns
`include "intra_consts.svh"

module mode_decision (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  logic [15:0]        lambda,
    cand_if.ctrl               cand,
    output intra_pkg::mode_e   mode,
    output logic               pred_load,
    output logic               q_start,
    output intra_pkg::mode_e   best_mode,
    output logic [31:0]        score,
    output intra_pkg::block_t  recon,
    output intra_pkg::levels_t levels,
    output logic [4:0]         nz,
    output logic               done
);

    typedef enum logic [2:0] {
        S_IDLE, S_PRED, S_QUANT, S_WAIT, S_SCORE, S_COMP, S_STORE, S_DONE
    } state_e;

    state_e           state;
    state_e           state_nx;
    intra_pkg::mode_e cur_mode;
    logic             first;
    logic             win;
    logic             last;
    logic [31:0]      cost;
    logic [31:0]      score_tmp;

    always_comb begin
        case (cur_mode)
            intra_pkg::DC: cost = 32'(`COST_DC);
            intra_pkg::TM: cost = 32'(`COST_TM);
            intra_pkg::VE: cost = 32'(`COST_VE);
            default:       cost = 32'(`COST_HE);
        endcase
    end

    // Ties go to the later mode
    assign win  = first || (score_tmp <= score);
    assign last = (cur_mode == intra_pkg::DC);

    // ------------------------------------------------------------
    // Candidate walk HE, VE, TM, DC
    // ------------------------------------------------------------
    always_comb begin
        state_nx = state;
        case (state)
            S_IDLE: begin
                if (start)
                    state_nx = S_PRED;
            end
            S_PRED:  state_nx = S_QUANT;
            S_QUANT: state_nx = S_WAIT;
            S_WAIT: begin
                if (cand.d_done)
                    state_nx = S_SCORE;
            end
            S_SCORE: state_nx = S_COMP;
            S_COMP:  state_nx = win ? S_STORE : (last ? S_DONE : S_PRED);
            S_STORE: state_nx = last ? S_DONE : S_PRED;
            default: state_nx = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            cur_mode  <= intra_pkg::HE;
            first     <= 1'b0;
            score_tmp <= '0;
            score     <= '0;
            best_mode <= intra_pkg::DC;
            nz        <= '0;
        end else begin
            state <= state_nx;
            case (state)
                S_IDLE: begin
                    cur_mode <= intra_pkg::HE;
                    first    <= 1'b1;
                end
                S_SCORE: begin
                    score_tmp <= ((32'(cand.rate) << 4) + cost) * 32'(lambda)
                                 + 32'(cand.sse);
                end
                S_COMP: begin
                    if (!win && !last)
                        cur_mode <= intra_pkg::mode_e'(cur_mode - 2'd1);
                end
                S_STORE: begin
                    first     <= 1'b0;
                    score     <= score_tmp;
                    best_mode <= cur_mode;
                    nz        <= cand.nz;
                    if (!last)
                        cur_mode <= intra_pkg::mode_e'(cur_mode - 2'd1);
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_STORE) begin
            recon  <= cand.recon;
            levels <= cand.levels;
        end
    end

    assign mode      = cur_mode;
    assign pred_load = (state == S_PRED);
    assign q_start   = (state == S_QUANT);
    assign done      = (state == S_DONE);

    // Datapath completions only while the FSM waits on them
    assert property (@(posedge clk) disable iff (!rst_n)
        (cand.q_done || cand.d_done) |-> state == S_WAIT)
        else $error("candidate done outside WAIT");

endmodule

// File: source/block_distortion.sv
// Starts on q_done and relies on recon and src holding for BLK cycles after it
`timescale 1ns/1ns
`include "intra_consts.svh"

module block_distortion (
    input  logic              clk,
    input  logic              rst_n,
    input  intra_pkg::block_t src,
    cand_if.disto             cand
);

    localparam int RW    = $clog2(`BLK);
    localparam int ROW_W = 16 + $clog2(`BLK);

    logic             busy;
    logic [RW-1:0]    row;
    logic [RW-1:0]    cur;
    logic [ROW_W-1:0] row_sse;
    logic [19:0]      sse_q;
    logic             done_q;

    assign cur = cand.q_done ? '0 : row;

    always_comb begin
        logic signed [8:0]  d;
        logic signed [17:0] sq;
        row_sse = '0;
        for (int c = 0; c < `BLK; c++) begin
            d       = $signed({1'b0, src[cur][c]}) - $signed({1'b0, cand.recon[cur][c]});
            sq      = d * d;
            row_sse = row_sse + ROW_W'(sq[15:0]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            row    <= '0;
            sse_q  <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (cand.q_done || busy) begin
                sse_q <= (cand.q_done ? 20'd0 : sse_q) + 20'(row_sse);
                if (cur == RW'(`BLK - 1)) begin
                    busy   <= 1'b0;
                    done_q <= 1'b1;
                end else begin
                    busy <= 1'b1;
                    row  <= cur + 1'b1;
                end
            end
        end
    end

    assign cand.sse    = sse_q;
    assign cand.d_done = done_q;

endmodule

// File: source/residual_quantizer.sv
// One power-of-two step set by qshift and no transform, so levels are pixel residuals
`timescale 1ns/1ns
`include "intra_consts.svh"

module residual_quantizer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              q_start,
    input  intra_pkg::block_t pred,
    input  intra_pkg::block_t src,
    input  logic [2:0]        qshift,
    cand_if.quant             cand
);

    localparam int RW   = $clog2(`BLK);
    localparam int NZ_W = $clog2(`BLK + 1);
    localparam int RT_W = 8 + $clog2(`BLK);

    logic                             busy;
    logic                             active;
    logic [RW-1:0]                    row;
    logic [RW-1:0]                    cur;
    intra_pkg::row_t                  rec_row;
    intra_pkg::level_t [`BLK-1:0]     lvl_row;
    logic [NZ_W-1:0]                  row_nz;
    logic [RT_W-1:0]                  row_rate;
    intra_pkg::block_t                recon_q;
    intra_pkg::levels_t               levels_q;
    logic [4:0]                       nz_q;
    logic [11:0]                      rate_q;
    logic                             done_q;

    // Row 0 is handled in the q_start cycle itself
    assign active = q_start | busy;
    assign cur    = q_start ? '0 : row;

    always_comb begin
        logic signed [9:0] res;
        logic signed [9:0] rec;
        logic [7:0]        mag;
        logic [7:0]        qmag;
        logic [7:0]        rmag;
        row_nz   = '0;
        row_rate = '0;
        for (int c = 0; c < `BLK; c++) begin
            res  = $signed({2'b00, src[cur][c]}) - $signed({2'b00, pred[cur][c]});
            mag  = (res < 0) ? 8'(-res) : res[7:0];
            qmag = mag >> qshift;
            rmag = qmag << qshift;
            if (res < 0) begin
                lvl_row[c] = -intra_pkg::level_t'(qmag);
                rec        = $signed({2'b00, pred[cur][c]}) - $signed({2'b00, rmag});
            end else begin
                lvl_row[c] = intra_pkg::level_t'(qmag);
                rec        = $signed({2'b00, pred[cur][c]}) + $signed({2'b00, rmag});
            end
            rec_row[c] = (rec < 0) ? 8'd0 : ((rec > 255) ? 8'd255 : rec[7:0]);
            row_nz     = row_nz + NZ_W'(qmag != 8'd0);
            row_rate   = row_rate + RT_W'(qmag);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            row    <= '0;
            nz_q   <= '0;
            rate_q <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (active) begin
                nz_q   <= (q_start ? 5'd0 : nz_q) + 5'(row_nz);
                rate_q <= (q_start ? 12'd0 : rate_q) + 12'(row_rate);
                if (cur == RW'(`BLK - 1)) begin
                    busy   <= 1'b0;
                    done_q <= 1'b1;
                end else begin
                    busy <= 1'b1;
                    row  <= cur + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (active) begin
            recon_q[cur] <= rec_row;
            for (int c = 0; c < `BLK; c++)
                levels_q[cur * `BLK + c] <= lvl_row[c];
        end
    end

    assign cand.recon  = recon_q;
    assign cand.levels = levels_q;
    assign cand.nz     = nz_q;
    assign cand.rate   = rate_q;
    assign cand.q_done = done_q;

    // Controller must wait for q_done before the next candidate
    assert property (@(posedge clk) disable iff (!rst_n) q_start |-> !busy)
        else $error("q_start while a block is in progress");

endmodule

// File: source/intra_predictor.sv
// Missing edges take the 127/129 fill and pred is valid the cycle after pred_load
`timescale 1ns/1ns
`include "intra_consts.svh"

module intra_predictor (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pred_load,
    input  intra_pkg::mode_e  mode,
    input  logic              have_top,
    input  logic              have_left,
    input  intra_pkg::pixel_t top_left,
    input  intra_pkg::row_t   top,
    input  intra_pkg::row_t   left,
    output intra_pkg::block_t pred
);

    localparam int SUM_W = 8 + $clog2(2 * `BLK);
    localparam int SH    = $clog2(`BLK);

    intra_pkg::row_t   top_e;
    intra_pkg::row_t   left_e;
    intra_pkg::pixel_t tl_e;
    intra_pkg::block_t pred_nx;
    logic [SUM_W-1:0]  sum_top;
    logic [SUM_W-1:0]  sum_left;
    logic [SUM_W-1:0]  dc_sum;

    // Edge fill and DC mean
    always_comb begin
        top_e  = have_top ? top : {`BLK{8'd127}};
        left_e = have_left ? left : {`BLK{8'd129}};
        if (!have_top)
            tl_e = 8'd127;
        else if (!have_left)
            tl_e = 8'd129;
        else
            tl_e = top_left;
        sum_top  = '0;
        sum_left = '0;
        for (int i = 0; i < `BLK; i++) begin
            sum_top  = sum_top + SUM_W'(top[i]);
            sum_left = sum_left + SUM_W'(left[i]);
        end
        case ({have_top, have_left})
            2'b11:   dc_sum = (sum_top + sum_left + SUM_W'(`BLK)) >> (SH + 1);
            2'b10:   dc_sum = (sum_top + SUM_W'(`BLK / 2)) >> SH;
            2'b01:   dc_sum = (sum_left + SUM_W'(`BLK / 2)) >> SH;
            default: dc_sum = SUM_W'(128);
        endcase
    end

    always_comb begin
        logic signed [9:0] tm;
        intra_pkg::pixel_t tm_c;
        for (int r = 0; r < `BLK; r++) begin
            for (int c = 0; c < `BLK; c++) begin
                tm = $signed({2'b00, left_e[r]}) + $signed({2'b00, top_e[c]})
                     - $signed({2'b00, tl_e});
                tm_c = (tm < 0) ? 8'd0 : ((tm > 255) ? 8'd255 : tm[7:0]);
                case (mode)
                    intra_pkg::DC: pred_nx[r][c] = dc_sum[7:0];
                    intra_pkg::TM: pred_nx[r][c] = tm_c;
                    intra_pkg::VE: pred_nx[r][c] = top_e[c];
                    default:       pred_nx[r][c] = left_e[r];
                endcase
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pred <= '0;
        else if (pred_load)
            pred <= pred_nx;
    end

endmodule

// File: source/cand_if.sv
// Candidate data holds from its done pulse until the next q_start
`timescale 1ns/1ns

interface cand_if;

    intra_pkg::block_t  recon;
    intra_pkg::levels_t levels;
    logic [4:0]         nz;
    logic [11:0]        rate;
    logic               q_done;
    logic [19:0]        sse;
    logic               d_done;

    modport quant (
        output recon, levels, nz, rate, q_done
    );

    modport disto (
        input  recon, q_done,
        output sse, d_done
    );

    modport ctrl (
        input recon, levels, nz, rate, q_done, sse, d_done
    );

endinterface

// File: source/intra_pkg.sv
// Pixels are 8 bits and the block and level sizes follow the shared constants header
`include "intra_consts.svh"

package intra_pkg;

    // Encoding also indexes the fixed cost table
    typedef enum logic [1:0] {
        DC = 2'd0,
        TM = 2'd1,
        VE = 2'd2,
        HE = 2'd3
    } mode_e;

    typedef logic [7:0] pixel_t;

    // Pixel 0 is the leftmost one
    typedef pixel_t [`BLK-1:0] row_t;

    // Row 0 is the top row
    typedef row_t [`BLK-1:0] block_t;

    typedef logic signed [`LVL_W-1:0] level_t;

    // Indexed by row * BLK + column
    typedef level_t [`NPIX-1:0] levels_t;

endpackage

// File: source/intra_consts.svh
// BLK must be a power of two and the nz, rate and sse widths only fit the 4x4 default
`ifndef INTRA_CONSTS_SVH
`define INTRA_CONSTS_SVH

// Block geometry
`define BLK   4
`define NPIX  (`BLK * `BLK)

// Signed level, wide enough for a full 8-bit residual
`define LVL_W 9

// Fixed header cost per intra mode
`define COST_DC 663
`define COST_TM 919
`define COST_VE 872
`define COST_HE 919

`endif
